/* Bender.yml */
package:
  name: fetch_front

sources:
  - fetch_pkg.sv
  - fetch_redirect_if.sv
  - fetch_bank_if.sv
  - fetch_redirect_decode.sv
  - fip_select.sv
  - itlb_lookup.sv
  - icache_bank.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - fetch_tb.sv

/* fetch_bank_if.sv */
`timescale 1ns/1ps

interface fetch_bank_if;

    fetch_pkg::fip_u              fip;
    logic [fetch_pkg::LINE_W-1:0] line;
    logic                         miss;
    logic                         tlb_miss;
    logic                         prot_fault;

    // address bank drives the lookup
    modport source (
        output fip,
        input  line, miss, tlb_miss, prot_fault
    );

    // cache bank answers in the same cycle
    modport sink (
        input  fip,
        output line, miss, tlb_miss, prot_fault
    );

endinterface

/* fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////////////////
    // widths

    localparam int unsigned FIP_W   = 28;   // va[31:4]
    localparam int unsigned LINE_W  = 128;
    localparam int unsigned VPN_W   = 20;
    localparam int unsigned PFN_W   = 3;    // 15-bit physical space
    localparam int unsigned IDX_W   = 4;    // 16 lines per bank
    localparam int unsigned TAG_W   = 6;
    localparam int unsigned PLINE_W = 11;   // pa[14:4]

    localparam int unsigned PAGE_LINE_W = FIP_W - VPN_W;  // lines within a 4k page
    localparam int unsigned UPPER_W     = TAG_W - PFN_W;  // line bits above the index

    ////////////////////////////////////////////////////
    // fetch address views

    // seen by the tlb
    typedef struct packed {
        logic [VPN_W-1:0]       vpn;
        logic [PAGE_LINE_W-1:0] line;
    } fip_page_t;

    // seen by the cache bank
    typedef struct packed {
        logic [VPN_W-1:0]   vpn;
        logic [UPPER_W-1:0] upper;
        logic [IDX_W-1:0]   idx;
        logic               par;   // va[4], even/odd bank
    } fip_cache_t;

    typedef union packed {
        fip_page_t  page;
        fip_cache_t cache;
    } fip_u;

    ////////////////////////////////////////////////////
    // next address source

    typedef enum logic [1:0] {
        SEQ     = 2'd0,
        BRANCH  = 2'd1,
        RESTEER = 2'd2,
        INIT    = 2'd3
    } redirect_sel_t;

endpackage

/* fetch_redirect_decode.sv */
`timescale 1ns/1ps

module fetch_redirect_decode (
    input  logic [31:0]       init_addr_i,
    input  logic              is_init_i,
    input  logic              is_resteer_i,
    input  logic              is_br_i,
    fetch_redirect_if.source  redir
);

    logic [fetch_pkg::FIP_W-1:0] init_base;
    logic [fetch_pkg::FIP_W-1:0] init_next;
    logic                        init_odd_first;

    ////////////////////////////////////////////////////
    // priority, init > resteer > branch

    always_comb begin
        if (is_init_i) begin
            redir.sel = fetch_pkg::INIT;
        end else if (is_resteer_i) begin
            redir.sel = fetch_pkg::RESTEER;
        end else if (is_br_i) begin
            redir.sel = fetch_pkg::BRANCH;
        end else begin
            redir.sel = fetch_pkg::SEQ;
        end
    end

    assign redir.is_cf = (redir.sel != fetch_pkg::SEQ);

    ////////////////////////////////////////////////////
    // init line pair

    assign init_base      = init_addr_i[31:4];
    assign init_next      = init_base + 1'b1;   // one incrementer shared by both banks
    assign init_odd_first = init_addr_i[4];

    // the bank that owns the base line takes it, the other one the line after
    assign redir.init_fip_even = init_odd_first ? init_next : init_base;
    assign redir.init_fip_odd  = init_odd_first ? init_base : init_next;

endmodule

/* fetch_redirect_if.sv */
`timescale 1ns/1ps

interface fetch_redirect_if;

    fetch_pkg::redirect_sel_t     sel;
    logic [fetch_pkg::FIP_W-1:0]  init_fip_even;
    logic [fetch_pkg::FIP_W-1:0]  init_fip_odd;
    logic                         is_cf;   // any redirect this cycle

    // decode side
    modport source (
        output sel,
        output init_fip_even,
        output init_fip_odd,
        output is_cf
    );

    // both address banks
    modport sink (
        input sel,
        input init_fip_even,
        input init_fip_odd,
        input is_cf
    );

endinterface

/* fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    localparam int TLB_ENTRIES = 8;
    localparam int FIP_W       = fetch_pkg::FIP_W;
    localparam int LINE_W      = fetch_pkg::LINE_W;
    localparam int VPN_W       = fetch_pkg::VPN_W;
    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 8;
    localparam int TEST_CYCLES = 5 + 9 + 7 + 5 + 5;   // init, priority, advance, tlb, fill
    localparam int MARGIN      = 20;

    localparam logic [19:0] VPN_MAPPED = 20'h00012;   // entry 0, frame 5
    localparam logic [19:0] VPN_PCD    = 20'h00034;   // entry 1, uncached
    localparam logic [19:0] VPN_NONE   = 20'h00056;
    localparam logic [2:0]  PFN_MAPPED = 3'd5;

    logic                     clk, arst_n;
    logic [31:0]              init_addr;
    logic                     is_init, is_resteer, is_br, ld_even, ld_odd;
    logic [FIP_W-1:0]         bp_fip_even, bp_fip_odd, wb_fip_even, wb_fip_odd;
    logic [VPN_W*TLB_ENTRIES-1:0] tlb_vp, tlb_pf;
    logic [TLB_ENTRIES-1:0]   tlb_v, tlb_pcd;
    logic                     fill_valid;
    logic [fetch_pkg::PLINE_W-1:0] fill_pline;
    logic [LINE_W-1:0]        fill_line, line_even, line_odd;
    logic [FIP_W-1:0]         fip_even, fip_odd;
    logic                     miss_even, miss_odd, tlb_miss_even, tlb_miss_odd;
    logic                     fault_even, fault_odd;

    logic [31:0]      lfsr_q = 32'h8fc39f0d;
    logic [FIP_W-1:0] exp_even_q;   // model of the fetch registers
    logic [FIP_W-1:0] exp_odd_q;
    int               errors, errs_start, test_count;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_tb_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    fetch_top #(.TLB_ENTRIES(TLB_ENTRIES)) i_fetch_top (
        .clk (clk), .arst_n_i (arst_n),
        .init_addr_i (init_addr), .is_init_i (is_init),
        .is_resteer_i (is_resteer), .is_br_i (is_br),
        .bp_fip_even_i (bp_fip_even), .bp_fip_odd_i (bp_fip_odd),
        .wb_fip_even_i (wb_fip_even), .wb_fip_odd_i (wb_fip_odd),
        .ld_even_i (ld_even), .ld_odd_i (ld_odd),
        .tlb_vp_i (tlb_vp), .tlb_pf_i (tlb_pf), .tlb_v_i (tlb_v), .tlb_pcd_i (tlb_pcd),
        .fill_valid_i (fill_valid), .fill_pline_i (fill_pline), .fill_line_i (fill_line),
        .fip_even_o (fip_even), .fip_odd_o (fip_odd),
        .line_even_o (line_even), .line_odd_o (line_odd),
        .miss_even_o (miss_even), .miss_odd_o (miss_odd),
        .tlb_miss_even_o (tlb_miss_even), .tlb_miss_odd_o (tlb_miss_odd),
        .prot_fault_even_o (fault_even), .prot_fault_odd_o (fault_odd)
    );

    //////////////////////////////////////////////////
    // reference model and stimulus helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [LINE_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[LINE_W-2:0], lfsr_q[0]};
        end
    endtask

    // {even, odd}, the bank owning va[4] gets the base line
    function automatic logic [2*FIP_W-1:0] init_pair(input logic [31:0] a);
        logic [FIP_W-1:0] base;
        base = a[31:4];
        if (a[4]) return {base + 1'b1, base};
        return {base, base + 1'b1};
    endfunction

    function automatic logic [FIP_W-1:0] advance(input logic [FIP_W-1:0] f, input logic par);
        logic [FIP_W-1:0] n;
        n = f + 28'd2;
        return {n[FIP_W-1:1], par};
    endfunction

    function automatic logic [10:0] phys_line(input logic [2:0] pfn, input logic [7:0] pl);
        return {pfn, pl};   // {tag, idx, parity}
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle();
        {is_init, is_resteer, is_br, ld_even, ld_odd, fill_valid} = '0;
    endtask

    task automatic check_fip(input string name, input fetch_pkg::fip_u exp,
                             input fetch_pkg::fip_u act);
        if (act !== exp) begin
            $display("CHECK FAILED %s fip expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s line expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // {miss, tlb_miss, prot_fault}
    task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s flags expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test();
        errs_start = errors;
        test_count++;
    endtask

    task automatic end_test(input string name);
        $display("%s done, %0d failed checks", name, errors - errs_start);
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_init_split();
        logic [LINE_W-1:0]  r;
        logic [2*FIP_W-1:0] pair;
        begin_test();
        for (int k = 0; k < 4; k++) begin
            rand_bits(32, r);
            next_cycle();
            init_addr = r[31:0];
            is_init   = 1'b1;
            pair      = init_pair(r[31:0]);
            @(negedge clk);
            check_fip("init_split", pair[2*FIP_W-1:FIP_W], fip_even);
            check_fip("init_split", pair[FIP_W-1:0], fip_odd);
        end
        next_cycle();
        idle();
        end_test("init_split");
    endtask

    task automatic test_priority();
        logic [LINE_W-1:0]  r;
        logic [2*FIP_W-1:0] pair;
        logic [FIP_W-1:0]   exp_e, exp_o;
        begin_test();
        rand_bits(4 * FIP_W, r);
        {bp_fip_even, bp_fip_odd, wb_fip_even, wb_fip_odd} = r[4*FIP_W-1:0];
        rand_bits(32, r);
        init_addr = r[31:0];
        pair      = init_pair(r[31:0]);
        for (int c = 0; c < 8; c++) begin
            next_cycle();
            {is_init, is_resteer, is_br} = c[2:0];
            @(negedge clk);
            if (is_init) begin
                {exp_e, exp_o} = pair;
            end else if (is_resteer) begin
                {exp_e, exp_o} = {wb_fip_even, wb_fip_odd};
            end else if (is_br) begin
                {exp_e, exp_o} = {bp_fip_even, bp_fip_odd};
            end else begin
                {exp_e, exp_o} = {exp_even_q, exp_odd_q};   // registers untouched so far
            end
            check_fip("priority", exp_e, fip_even);
            check_fip("priority", exp_o, fip_odd);
        end
        next_cycle();
        idle();
        end_test("priority");
    endtask

    task automatic test_seq_advance();
        begin_test();
        is_br      = 1'b1;   // branch target seeds both registers
        ld_even    = 1'b1;
        ld_odd     = 1'b1;
        exp_even_q = bp_fip_even;
        exp_odd_q  = bp_fip_odd;
        for (int c = 0; c < 6; c++) begin
            if (c > 0) begin
                next_cycle();
                is_br = 1'b0;
            end
            if (c == 4) {ld_even, ld_odd} = 2'b00;   // hold from here
            @(negedge clk);
            check_fip("seq_advance", exp_even_q, fip_even);
            check_fip("seq_advance", exp_odd_q, fip_odd);
            if (ld_even) exp_even_q = advance(exp_even_q, 1'b0);
            if (ld_odd) exp_odd_q = advance(exp_odd_q, 1'b1);
        end
        next_cycle();
        idle();
        end_test("seq_advance");
    endtask

    task automatic test_tlb_flags();
        logic [LINE_W-1:0] fill_data;
        begin_test();
        rand_bits(LINE_W, fill_data);
        // valid lines at the looked-up index, so only the flags keep the line at zero
        fill_valid = 1'b1;
        fill_pline = phys_line(3'd0, 8'h10);   // even, frame 0
        fill_line  = fill_data;
        next_cycle();
        fill_pline = phys_line(3'd2, 8'h11);   // odd, frame of the pcd entry
        next_cycle();
        fill_valid = 1'b0;
        init_addr = {VPN_NONE, 8'h10, 4'h0};
        is_init   = 1'b1;
        @(negedge clk);
        check_flags("tlb_flags", 3'b010, {miss_even, tlb_miss_even, fault_even});
        check_flags("tlb_flags", 3'b010, {miss_odd, tlb_miss_odd, fault_odd});
        check_line("tlb_flags", '0, line_even);
        next_cycle();
        init_addr = {VPN_PCD, 8'h10, 4'h0};
        @(negedge clk);
        check_flags("tlb_flags", 3'b001, {miss_even, tlb_miss_even, fault_even});
        check_flags("tlb_flags", 3'b001, {miss_odd, tlb_miss_odd, fault_odd});
        check_line("tlb_flags", '0, line_odd);
        next_cycle();
        idle();
        end_test("tlb_flags");
    endtask

    task automatic test_fill_hit();
        logic [LINE_W-1:0] data_a, data_b;
        begin_test();
        rand_bits(LINE_W, data_a);
        rand_bits(LINE_W, data_b);
        init_addr = {VPN_MAPPED, 8'h26, 4'h0};   // even line 0x26, odd line 0x27
        is_init   = 1'b1;
        @(negedge clk);
        check_flags("fill_hit", 3'b100, {miss_even, tlb_miss_even, fault_even});
        check_line("fill_hit", '0, line_even);
        next_cycle();
        fill_valid = 1'b1;   // odd parity first
        fill_pline = phys_line(PFN_MAPPED, 8'h27);
        fill_line  = data_a;
        next_cycle();
        fill_pline = phys_line(PFN_MAPPED, 8'h26);
        fill_line  = data_b;
        @(negedge clk);
        check_flags("fill_hit", 3'b100, {miss_even, tlb_miss_even, fault_even});
        check_flags("fill_hit", 3'b000, {miss_odd, tlb_miss_odd, fault_odd});
        check_line("fill_hit", data_a, line_odd);
        next_cycle();
        fill_valid = 1'b0;
        @(negedge clk);
        check_flags("fill_hit", 3'b000, {miss_even, tlb_miss_even, fault_even});
        check_line("fill_hit", data_b, line_even);
        check_line("fill_hit", data_a, line_odd);   // even fill left the odd bank alone
        next_cycle();
        idle();
        end_test("fill_hit");
    endtask

    //////////////////////////////////////////////////
    // sequence and watchdog

    initial begin
        idle();
        init_addr  = '0;
        {bp_fip_even, bp_fip_odd, wb_fip_even, wb_fip_odd} = '0;
        fill_pline = '0;
        fill_line  = '0;
        tlb_vp     = '0;
        tlb_pf     = '0;
        tlb_pcd    = 8'b0000_0010;
        tlb_v      = 8'b0000_0011;
        tlb_vp[0*VPN_W +: VPN_W] = VPN_MAPPED;
        tlb_pf[0*VPN_W +: VPN_W] = {17'd0, PFN_MAPPED};
        tlb_vp[1*VPN_W +: VPN_W] = VPN_PCD;
        tlb_pf[1*VPN_W +: VPN_W] = 20'h00002;
        exp_even_q = '0;   // reset value, parity pinned
        exp_odd_q  = 28'd1;
        errors     = 0;
        test_count = 0;
        @(posedge arst_n);
        next_cycle();
        test_init_split();
        test_priority();
        test_seq_advance();
        test_tlb_flags();
        test_fill_hit();
        $display("%0d tests run, %0d checks failed", test_count, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                                    clk,
    input  logic                                    arst_n_i,
    // redirect sources
    input  logic [31:0]                             init_addr_i,
    input  logic                                    is_init_i,
    input  logic                                    is_resteer_i,
    input  logic                                    is_br_i,
    input  logic [fetch_pkg::FIP_W-1:0]             bp_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]             bp_fip_odd_i,
    input  logic [fetch_pkg::FIP_W-1:0]             wb_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]             wb_fip_odd_i,
    input  logic                                    ld_even_i,
    input  logic                                    ld_odd_i,
    // tlb contents
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0] tlb_vp_i,
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0] tlb_pf_i,
    input  logic [TLB_ENTRIES-1:0]                  tlb_v_i,
    input  logic [TLB_ENTRIES-1:0]                  tlb_pcd_i,
    // line fill
    input  logic                                    fill_valid_i,
    input  logic [fetch_pkg::PLINE_W-1:0]           fill_pline_i,
    input  logic [fetch_pkg::LINE_W-1:0]            fill_line_i,
    // fetch results
    output logic [fetch_pkg::FIP_W-1:0]             fip_even_o,
    output logic [fetch_pkg::FIP_W-1:0]             fip_odd_o,
    output logic [fetch_pkg::LINE_W-1:0]            line_even_o,
    output logic [fetch_pkg::LINE_W-1:0]            line_odd_o,
    output logic                                    miss_even_o,
    output logic                                    miss_odd_o,
    output logic                                    tlb_miss_even_o,
    output logic                                    tlb_miss_odd_o,
    output logic                                    prot_fault_even_o,
    output logic                                    prot_fault_odd_o
);

    fetch_redirect_if redir ();
    fetch_bank_if     bank_even ();
    fetch_bank_if     bank_odd ();

    fetch_redirect_decode i_fetch_redirect_decode (
        .init_addr_i  (init_addr_i),
        .is_init_i    (is_init_i),
        .is_resteer_i (is_resteer_i),
        .is_br_i      (is_br_i),
        .redir        (redir)
    );

    ////////////////////////////////////////////////////
    // even bank

    fip_select #(.PARITY(1'b0)) i_fip_select_even (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .redir          (redir),
        .redirect_fip_i (bp_fip_even_i),
        .resteer_fip_i  (wb_fip_even_i),
        .ld_i           (ld_even_i),
        .bank           (bank_even)
    );

    icache_bank #(.TLB_ENTRIES(TLB_ENTRIES), .PARITY(1'b0)) i_icache_bank_even (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .bank         (bank_even),
        .tlb_vp_i     (tlb_vp_i),
        .tlb_pf_i     (tlb_pf_i),
        .tlb_v_i      (tlb_v_i),
        .tlb_pcd_i    (tlb_pcd_i),
        .fill_valid_i (fill_valid_i),
        .fill_pline_i (fill_pline_i),
        .fill_line_i  (fill_line_i)
    );

    ////////////////////////////////////////////////////
    // odd bank

    fip_select #(.PARITY(1'b1)) i_fip_select_odd (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .redir          (redir),
        .redirect_fip_i (bp_fip_odd_i),
        .resteer_fip_i  (wb_fip_odd_i),
        .ld_i           (ld_odd_i),
        .bank           (bank_odd)
    );

    icache_bank #(.TLB_ENTRIES(TLB_ENTRIES), .PARITY(1'b1)) i_icache_bank_odd (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .bank         (bank_odd),
        .tlb_vp_i     (tlb_vp_i),
        .tlb_pf_i     (tlb_pf_i),
        .tlb_v_i      (tlb_v_i),
        .tlb_pcd_i    (tlb_pcd_i),
        .fill_valid_i (fill_valid_i),   // bank drops fills of the other parity
        .fill_pline_i (fill_pline_i),
        .fill_line_i  (fill_line_i)
    );

    assign fip_even_o        = bank_even.fip;
    assign fip_odd_o         = bank_odd.fip;
    assign line_even_o       = bank_even.line;
    assign line_odd_o        = bank_odd.line;
    assign miss_even_o       = bank_even.miss;
    assign miss_odd_o        = bank_odd.miss;
    assign tlb_miss_even_o   = bank_even.tlb_miss;
    assign tlb_miss_odd_o    = bank_odd.tlb_miss;
    assign prot_fault_even_o = bank_even.prot_fault;
    assign prot_fault_odd_o  = bank_odd.prot_fault;

endmodule

/* fip_select.sv */
`timescale 1ns/1ps

module fip_select #(
    parameter bit PARITY = 1'b0
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    fetch_redirect_if.sink              redir,
    input  logic [fetch_pkg::FIP_W-1:0] redirect_fip_i,   // branch target
    input  logic [fetch_pkg::FIP_W-1:0] resteer_fip_i,
    input  logic                        ld_i,
    fetch_bank_if.source                bank
);

    localparam int unsigned FIP_W = fetch_pkg::FIP_W;

    logic [FIP_W-1:0] fip_q;
    logic [FIP_W-1:0] cf_fip;
    logic [FIP_W-1:0] fip_w;
    logic [FIP_W-1:0] fip_inc;

    // control flow address
    always_comb begin
        case (redir.sel)
            fetch_pkg::INIT:    cf_fip = PARITY ? redir.init_fip_odd : redir.init_fip_even;
            fetch_pkg::RESTEER: cf_fip = resteer_fip_i;
            fetch_pkg::BRANCH:  cf_fip = redirect_fip_i;
            default:            cf_fip = '0;   // seq, masked by is_cf below
        endcase
    end

    assign fip_w    = redir.is_cf ? cf_fip : fip_q;
    assign bank.fip = fip_w;

    ////////////////////////////////////////////////////
    // sequential fetch register

    // the other bank covers the line in between
    assign fip_inc = fip_w + 2'd2;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fip_q <= {{(FIP_W-1){1'b0}}, PARITY};
        end else if (ld_i) begin
            fip_q <= {fip_inc[FIP_W-1:1], PARITY};   // parity bit pinned
        end
    end

endmodule

/* icache_bank.sv */
`timescale 1ns/1ps

module icache_bank #(
    parameter int TLB_ENTRIES = 8,
    parameter bit PARITY      = 1'b0
) (
    input  logic                                    clk,
    input  logic                                    arst_n_i,
    fetch_bank_if.sink                              bank,
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0] tlb_vp_i,
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0] tlb_pf_i,
    input  logic [TLB_ENTRIES-1:0]                  tlb_v_i,
    input  logic [TLB_ENTRIES-1:0]                  tlb_pcd_i,
    input  logic                                    fill_valid_i,
    input  logic [fetch_pkg::PLINE_W-1:0]           fill_pline_i,
    input  logic [fetch_pkg::LINE_W-1:0]            fill_line_i
);

    localparam int unsigned IDX_W  = fetch_pkg::IDX_W;
    localparam int unsigned TAG_W  = fetch_pkg::TAG_W;
    localparam int unsigned LINE_W = fetch_pkg::LINE_W;
    localparam int unsigned LINES  = 2 ** IDX_W;

    logic [LINE_W-1:0] data_q [LINES];
    logic [TAG_W-1:0]  tag_q  [LINES];
    logic [LINES-1:0]  valid_q;

    logic [fetch_pkg::PFN_W-1:0] pfn;
    logic                        tlb_miss;
    logic                        prot_fault;
    logic                        xlate_ok;
    logic [IDX_W-1:0]            rd_idx;
    logic [TAG_W-1:0]            rd_tag;
    logic                        tag_hit;
    logic                        fill_en;
    logic [IDX_W-1:0]            wr_idx;
    logic [TAG_W-1:0]            wr_tag;

    ////////////////////////////////////////////////////
    // translation

    itlb_lookup #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_itlb_lookup (
        .fip_i        (bank.fip),
        .tlb_vp_i     (tlb_vp_i),
        .tlb_pf_i     (tlb_pf_i),
        .tlb_v_i      (tlb_v_i),
        .tlb_pcd_i    (tlb_pcd_i),
        .pfn_o        (pfn),
        .tlb_miss_o   (tlb_miss),
        .prot_fault_o (prot_fault)
    );

    assign xlate_ok = !tlb_miss && !prot_fault;

    ////////////////////////////////////////////////////
    // lookup, same cycle as the address

    assign rd_idx  = bank.fip.cache.idx;
    assign rd_tag  = {pfn, bank.fip.cache.upper};   // physical line bits above index
    assign tag_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    assign bank.tlb_miss   = tlb_miss;
    assign bank.prot_fault = prot_fault;
    assign bank.miss       = xlate_ok && !tag_hit;
    assign bank.line       = (xlate_ok && tag_hit) ? data_q[rd_idx] : '0;

    ////////////////////////////////////////////////////
    // fill

    // pline = {tag, idx, parity}
    assign fill_en = fill_valid_i && (fill_pline_i[0] == PARITY);
    assign wr_idx  = fill_pline_i[IDX_W:1];
    assign wr_tag  = fill_pline_i[fetch_pkg::PLINE_W-1 -: TAG_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[wr_idx] <= fill_line_i;
            tag_q[wr_idx]  <= wr_tag;
        end
    end

endmodule

/* itlb_lookup.sv */
`timescale 1ns/1ps

module itlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  fetch_pkg::fip_u                                  fip_i,
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0]          tlb_vp_i,
    input  logic [fetch_pkg::VPN_W*TLB_ENTRIES-1:0]          tlb_pf_i,
    input  logic [TLB_ENTRIES-1:0]                           tlb_v_i,
    input  logic [TLB_ENTRIES-1:0]                           tlb_pcd_i,
    output logic [fetch_pkg::PFN_W-1:0]                      pfn_o,
    output logic                                             tlb_miss_o,
    output logic                                             prot_fault_o
);

    localparam int unsigned VPN_W = fetch_pkg::VPN_W;
    localparam int unsigned PFN_W = fetch_pkg::PFN_W;

    logic             hit;
    logic             hit_pcd;
    logic [VPN_W-1:0] hit_pf;

    ////////////////////////////////////////////////////
    // fully associative match

    // scan downward so the lowest matching entry is the one kept
    always_comb begin
        hit     = 1'b0;
        hit_pcd = 1'b0;
        hit_pf  = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_v_i[i] && (tlb_vp_i[i*VPN_W +: VPN_W] == fip_i.page.vpn)) begin
                hit     = 1'b1;
                hit_pcd = tlb_pcd_i[i];
                hit_pf  = tlb_pf_i[i*VPN_W +: VPN_W];
            end
        end
    end

    // only the low frame bits exist in the physical space
    assign pfn_o = hit_pf[PFN_W-1:0];

    assign tlb_miss_o = !hit;

    // pcd page is mmio, no instruction fetch from it
    assign prot_fault_o = hit && hit_pcd;

endmodule

/* sources.f */
fetch_pkg.sv
fetch_redirect_if.sv
fetch_bank_if.sv
fetch_redirect_decode.sv
fip_select.sv
itlb_lookup.sv
icache_bank.sv
fetch_top.sv
tb_clk_gen.sv
fetch_tb.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 arst_n_o = 1'b1;   // released just off the edge
    end

endmodule
